/* build.f */
common/rv64_pkg.sv
source/adder64.sv
exe/exe_stage.sv
source/id_stage.sv
source/exe_result_reg.sv
source/exe_top.sv
verification/exe_tb.sv

/* common/rv64_pkg.sv */
package rv64_pkg;

	// ========================================
	// widths and constants
	// ========================================
	localparam int xlen = 64;                          // data path width

	typedef logic [xlen-1:0] reg_bus_t;                // operands and results

	localparam logic [xlen-1:0] zero_word = {xlen{1'b0}};

	// ========================================
	// alu operations
	// ========================================
	typedef enum logic [4:0] {
		alu_nop,                                       // unsupported encoding
		alu_add,
		alu_addw,
		alu_sub,
		alu_subw,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_or,
		alu_and,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_sllw,
		alu_srlw,
		alu_sraw,
		alu_lui,
		alu_beq,
		alu_bne,
		alu_blt,
		alu_bge,
		alu_bltu,
		alu_bgeu
	} alu_op_t;

	// ========================================
	// major opcodes, instr[6:0]
	// ========================================
	localparam logic [6:0] op_reg    = 7'b0110011;    // add, sub, slt ...
	localparam logic [6:0] op_imm    = 7'b0010011;    // addi, slti ...
	localparam logic [6:0] op_regw   = 7'b0111011;    // addw, subw, sllw ...
	localparam logic [6:0] op_immw   = 7'b0011011;    // addiw, slliw ...
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_branch = 7'b1100011;    // beq .. bgeu

endpackage

/* exe/exe_stage.sv */
`timescale 1ns/100ps

module exe_stage
	import rv64_pkg::*;
(
	input  logic     rst,
	input  alu_op_t  alu_op,
	input  reg_bus_t op1,
	input  reg_bus_t op2,
	output reg_bus_t rd_data,
	output logic     b_flag      // branch condition met
);

	logic        cin;
	reg_bus_t    b_in;           // op2 or its inverse
	reg_bus_t    result_add;
	logic        overflow;
	logic        sign;
	logic        carry;
	logic        zero;
	logic        is_branch_op;
	logic        lt_signed;

	reg_bus_t    sll_result;
	reg_bus_t    srl_result;
	reg_bus_t    sra_result;
	logic [31:0] sll_result32;
	logic [31:0] srl_result32;
	logic [31:0] sra_result32;

	// ========================================
	// shared adder
	// ========================================
	always_comb begin
		case (alu_op)
			alu_sub, alu_subw, alu_slt, alu_sltu,
			alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu: begin
				b_in = ~op2; // a - b as a + ~b + 1
				cin  = 1'b1;
			end
			default: begin
				b_in = op2;
				cin  = 1'b0;
			end
		endcase
	end

	adder64 u_adder64 (
		.a        (op1),
		.b        (b_in),
		.cin      (cin),
		.sum      (result_add),
		.overflow (overflow),
		.sign     (sign),
		.cout     (),
		.carry    (carry),
		.zero     (zero)
	);

	assign lt_signed    = sign ^ overflow;
	assign is_branch_op = alu_op inside {alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu};

	// ========================================
	// shifter
	// ========================================
	assign sll_result   = op1 << op2[5:0];                     // six shift bits
	assign srl_result   = op1 >> op2[5:0];
	assign sra_result   = $signed(op1) >>> op2[5:0];
	assign sll_result32 = op1[31:0] << op2[4:0];               // low word only
	assign srl_result32 = op1[31:0] >> op2[4:0];
	assign sra_result32 = $signed(op1[31:0]) >>> op2[4:0];

	// ========================================
	// result select
	// ========================================
	always_comb begin
		if (rst) begin
			rd_data = zero_word;
		end else begin
			case (alu_op)
				alu_add, alu_sub: rd_data = result_add;
				alu_addw, alu_subw: rd_data = {{32{result_add[31]}}, result_add[31:0]};
				alu_slt:  rd_data = {{(xlen-1){1'b0}}, lt_signed};
				alu_sltu: rd_data = {{(xlen-1){1'b0}}, carry};  // borrow means op1 < op2
				alu_xor:  rd_data = op1 ^ op2;
				alu_or:   rd_data = op1 | op2;
				alu_and:  rd_data = op1 & op2;
				alu_sll:  rd_data = sll_result;
				alu_srl:  rd_data = srl_result;
				alu_sra:  rd_data = sra_result;
				alu_sllw: rd_data = {{32{sll_result32[31]}}, sll_result32};
				alu_srlw: rd_data = {{32{srl_result32[31]}}, srl_result32};
				alu_sraw: rd_data = {{32{sra_result32[31]}}, sra_result32};
				alu_lui:  rd_data = op2;                    // immediate already placed
				default:  rd_data = zero_word;
			endcase
		end
	end

	// ========================================
	// branch condition
	// ========================================
	always_comb begin
		if (rst) begin
			b_flag = 1'b0;
		end else begin
			case (alu_op)
				alu_beq:  b_flag = zero;
				alu_bne:  b_flag = ~zero;
				alu_blt:  b_flag = lt_signed;
				alu_bge:  b_flag = ~lt_signed;
				alu_bltu: b_flag = carry;
				alu_bgeu: b_flag = ~carry;
				default:  b_flag = 1'b0;
			endcase
		end
	end

	// only branch operations raise the flag
	always_comb begin
		if (!rst && b_flag) begin
			assert (is_branch_op)
			else $error("exe_stage: b_flag high for alu_op %0d", alu_op);
		end
	end

endmodule

/* run.sh */
#!/bin/sh
verilator --binary --assert --timescale 1ns/100ps --top-module exe_tb -f build.f -o exe_sim \
	&& ./obj_dir/exe_sim | tee /dev/stderr | grep -qx "=== PASS ===" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* source/adder64.sv */
`timescale 1ns/100ps

module adder64
	import rv64_pkg::*;
(
	input  reg_bus_t a,
	input  reg_bus_t b,
	input  logic     cin,
	output reg_bus_t sum,
	output logic     overflow,
	output logic     sign,
	output logic     cout,
	output logic     carry,
	output logic     zero
);

	logic [xlen:0] full_sum; // one extra bit for carry out

	assign full_sum = {1'b0, a} + {1'b0, b} + {{xlen{1'b0}}, cin};
	assign sum      = full_sum[xlen-1:0];
	assign cout     = full_sum[xlen];

	// ========================================
	// flags
	// ========================================
	// signed overflow when both inputs agree in sign and the result does not
	assign overflow = (a[xlen-1] == b[xlen-1]) && (sum[xlen-1] != a[xlen-1]);
	assign sign     = sum[xlen-1];
	assign carry    = ~cout;               // borrow for a - b
	assign zero     = (sum == zero_word);

endmodule

/* source/exe_result_reg.sv */
`timescale 1ns/100ps

module exe_result_reg
	import rv64_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       instr_valid,
	input  reg_bus_t   pc,
	input  reg_bus_t   rd_data,
	input  logic       b_flag,
	input  logic [4:0] rd_addr,
	input  logic       rd_wen,
	input  logic       is_branch,
	input  reg_bus_t   br_offset,
	output logic       wb_valid,
	output logic [4:0] wb_rd_addr,
	output reg_bus_t   wb_data,
	output logic       wb_wen,
	output logic       br_taken,
	output reg_bus_t   br_target
);

	reg_bus_t target;
	logic     wen_next;
	logic     taken_next;

	assign target     = pc + br_offset;                               // pc-relative
	assign wen_next   = rd_wen && (rd_addr != 5'd0);                 // x0 never written
	assign taken_next = is_branch && b_flag;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid   <= 1'b0;
			wb_wen     <= 1'b0;
			br_taken   <= 1'b0;
			wb_rd_addr <= 5'd0;
			wb_data    <= zero_word;
			br_target  <= zero_word;
		end else begin
			wb_valid <= instr_valid;                  // one result per strobe
			wb_wen   <= instr_valid && wen_next;
			br_taken <= instr_valid && taken_next;
			if (instr_valid) begin
				wb_rd_addr <= rd_addr;                // payload holds between strobes
				wb_data    <= rd_data;
				br_target  <= target;
			end
		end
	end

	// a result is either a register write or a taken branch, never both
	a_wen_taken_excl: assert property (@(posedge clk) disable iff (rst)
		!(wb_wen && br_taken));

endmodule

/* source/exe_top.sv */
`timescale 1ns/100ps

module exe_top
	import rv64_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        instr_valid,  // one-cycle strobe
	input  logic [31:0] instr,
	input  reg_bus_t    pc,
	input  reg_bus_t    rs1_data,
	input  reg_bus_t    rs2_data,
	output logic        wb_valid,
	output logic [4:0]  wb_rd_addr,
	output reg_bus_t    wb_data,
	output logic        wb_wen,
	output logic        br_taken,
	output reg_bus_t    br_target
);

	alu_op_t    alu_op;
	reg_bus_t   op1;
	reg_bus_t   op2;
	logic [4:0] rd_addr;
	logic       rd_wen;
	logic       is_branch;
	reg_bus_t   br_offset;
	reg_bus_t   rd_data;
	logic       b_flag;

	// ========================================
	// decode, execute, register
	// ========================================
	id_stage u_id_stage (
		.instr     (instr),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.alu_op    (alu_op),
		.op1       (op1),
		.op2       (op2),
		.rd_addr   (rd_addr),
		.rd_wen    (rd_wen),
		.is_branch (is_branch),
		.br_offset (br_offset)
	);

	exe_stage u_exe_stage (
		.rst     (rst),
		.alu_op  (alu_op),
		.op1     (op1),
		.op2     (op2),
		.rd_data (rd_data),
		.b_flag  (b_flag)
	);

	exe_result_reg u_exe_result_reg (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.pc          (pc),
		.rd_data     (rd_data),
		.b_flag      (b_flag),
		.rd_addr     (rd_addr),
		.rd_wen      (rd_wen),
		.is_branch   (is_branch),
		.br_offset   (br_offset),
		.wb_valid    (wb_valid),
		.wb_rd_addr  (wb_rd_addr),
		.wb_data     (wb_data),
		.wb_wen      (wb_wen),
		.br_taken    (br_taken),
		.br_target   (br_target)
	);

endmodule

/* source/id_stage.sv */
`timescale 1ns/100ps

module id_stage
	import rv64_pkg::*;
(
	input  logic [31:0] instr,
	input  reg_bus_t    rs1_data,
	input  reg_bus_t    rs2_data,
	output alu_op_t     alu_op,
	output reg_bus_t    op1,
	output reg_bus_t    op2,
	output logic [4:0]  rd_addr,
	output logic        rd_wen,
	output logic        is_branch,
	output reg_bus_t    br_offset
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       f7_zero;       // funct7 all zero
	logic       f7_alt;        // sub / sra form
	logic       f6_zero;       // 64-bit shift immediates
	logic       f6_alt;
	reg_bus_t   imm_i;
	reg_bus_t   imm_u;

	assign opcode  = instr[6:0];
	assign funct3  = instr[14:12];
	assign f7_zero = (instr[31:25] == 7'b0000000);
	assign f7_alt  = (instr[31:25] == 7'b0100000);
	assign f6_zero = (instr[31:26] == 6'b000000);  // shamt bit 5 sits in instr[25]
	assign f6_alt  = (instr[31:26] == 6'b010000);
	assign rd_addr = instr[11:7];
	assign op1     = rs1_data;

	// ========================================
	// immediates
	// ========================================
	assign imm_i     = {{52{instr[31]}}, instr[31:20]};
	assign imm_u     = {{32{instr[31]}}, instr[31:12], 12'b0};
	assign br_offset = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

	// ========================================
	// operation decode
	// ========================================
	always_comb begin
		alu_op    = alu_nop;
		op2       = rs2_data;
		is_branch = 1'b0;
		case (opcode)
			op_reg: begin
				case (funct3)
					3'b000: alu_op = f7_zero ? alu_add : (f7_alt ? alu_sub : alu_nop);
					3'b001: alu_op = f7_zero ? alu_sll : alu_nop;
					3'b010: alu_op = f7_zero ? alu_slt : alu_nop;
					3'b011: alu_op = f7_zero ? alu_sltu : alu_nop;
					3'b100: alu_op = f7_zero ? alu_xor : alu_nop;
					3'b101: alu_op = f7_zero ? alu_srl : (f7_alt ? alu_sra : alu_nop);
					3'b110: alu_op = f7_zero ? alu_or : alu_nop;
					default: alu_op = f7_zero ? alu_and : alu_nop;
				endcase
			end
			op_imm: begin
				op2 = imm_i;
				case (funct3)
					3'b000: alu_op = alu_add;
					3'b001: alu_op = f6_zero ? alu_sll : alu_nop;
					3'b010: alu_op = alu_slt;
					3'b011: alu_op = alu_sltu;
					3'b100: alu_op = alu_xor;
					3'b101: alu_op = f6_zero ? alu_srl : (f6_alt ? alu_sra : alu_nop);
					3'b110: alu_op = alu_or;
					default: alu_op = alu_and;
				endcase
			end
			op_regw, op_immw: begin
				if (opcode == op_immw) begin
					op2 = imm_i;
				end
				case (funct3)
					3'b000: begin
						if (opcode == op_immw) begin
							alu_op = alu_addw;                       // addiw, no funct7
						end else begin
							alu_op = f7_zero ? alu_addw : (f7_alt ? alu_subw : alu_nop);
						end
					end
					3'b001: alu_op = f7_zero ? alu_sllw : alu_nop;
					3'b101: alu_op = f7_zero ? alu_srlw : (f7_alt ? alu_sraw : alu_nop);
					default: alu_op = alu_nop;
				endcase
			end
			op_lui: begin
				op2    = imm_u;
				alu_op = alu_lui;
			end
			op_branch: begin
				case (funct3)
					3'b000: alu_op = alu_beq;
					3'b001: alu_op = alu_bne;
					3'b100: alu_op = alu_blt;
					3'b101: alu_op = alu_bge;
					3'b110: alu_op = alu_bltu;
					3'b111: alu_op = alu_bgeu;
					default: alu_op = alu_nop;
				endcase
				is_branch = (alu_op != alu_nop);
			end
			default: alu_op = alu_nop;
		endcase
		rd_wen = (alu_op != alu_nop) && !is_branch;
	end

endmodule

/* verification/exe_tb.sv */
`timescale 1ns/100ps

module exe_tb
	import rv64_pkg::*;
();

	logic        clk;
	logic        rst;
	logic        instr_valid;
	logic [31:0] instr;
	reg_bus_t    pc;
	reg_bus_t    rs1_data;
	reg_bus_t    rs2_data;
	logic        wb_valid;
	logic [4:0]  wb_rd_addr;
	reg_bus_t    wb_data;
	logic        wb_wen;
	logic        br_taken;
	reg_bus_t    br_target;

	logic        exp_valid;          // result due on the outputs now
	logic        exp_alu;
	logic        exp_wen;
	logic        exp_taken;
	logic [4:0]  exp_rd;
	reg_bus_t    exp_data;
	reg_bus_t    exp_target;
	reg_bus_t    m_data;
	reg_bus_t    m_target;
	logic        m_alu;
	logic        m_taken;
	logic        rst_d1 = 1'b0;
	logic        rst_d2 = 1'b0;
	logic        timed_out = 1'b0;
	int          seed = 85320;
	int          errors = 0;
	int          issued = 0;
	int          tests = 0;
	int          test_base = 0;
	logic [2:0]  alu_f3 [0:6] = '{3'd0, 3'd0, 3'd4, 3'd6, 3'd7, 3'd2, 3'd3};
	logic [2:0]  br_f3 [0:5] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

	exe_top u_exe_top (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ========================================
	// reference model, RV64I rules
	// ========================================
	function automatic void ref_model(input logic [31:0] ins, input reg_bus_t a,
		input reg_bus_t b, input reg_bus_t pc_in, output reg_bus_t data,
		output logic alu, output logic taken, output reg_bus_t target);
		reg_bus_t    src2;
		logic [31:0] w;
		src2   = (ins[6:0] == op_imm || ins[6:0] == op_immw) ?
			{{52{ins[31]}}, ins[31:20]} : b;
		target = pc_in + {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		data   = zero_word;
		alu    = 1'b1;
		taken  = 1'b0;
		w      = 32'h0;
		case (ins[6:0])
			op_reg, op_imm: begin
				case (ins[14:12])
					3'd0: data = (ins[6:0] == op_reg && ins[30]) ? a - src2 : a + src2;
					3'd1: data = a << src2[5:0];
					3'd2: data = ($signed(a) < $signed(src2)) ? 64'd1 : 64'd0;
					3'd3: data = (a < src2) ? 64'd1 : 64'd0;
					3'd4: data = a ^ src2;
					3'd5: data = ins[30] ? reg_bus_t'($signed(a) >>> src2[5:0])
						: (a >> src2[5:0]);
					3'd6: data = a | src2;
					default: data = a & src2;
				endcase
			end
			op_regw, op_immw: begin
				case (ins[14:12])
					3'd0: w = (ins[6:0] == op_regw && ins[30]) ? a[31:0] - src2[31:0]
						: a[31:0] + src2[31:0];
					3'd1: w = a[31:0] << src2[4:0];
					3'd5: w = ins[30] ? 32'($signed(a[31:0]) >>> src2[4:0])
						: (a[31:0] >> src2[4:0]);
					default: alu = 1'b0;
				endcase
				data = {{32{w[31]}}, w};  // low word sign extended
			end
			op_lui: data = {{32{ins[31]}}, ins[31:12], 12'h000};
			op_branch: begin
				alu = 1'b0;
				case (ins[14:12])
					3'd0: taken = (a == b);
					3'd1: taken = (a != b);
					3'd4: taken = ($signed(a) < $signed(b));
					3'd5: taken = ($signed(a) >= $signed(b));
					3'd6: taken = (a < b);
					3'd7: taken = (a >= b);
					default: taken = 1'b0;
				endcase
			end
			default: alu = 1'b0;
		endcase
	endfunction

	always @(posedge clk) begin
		rst_d1 <= rst;
		rst_d2 <= rst_d1;
		ref_model(instr, rs1_data, rs2_data, pc, m_data, m_alu, m_taken, m_target);
		if (rst) begin
			exp_valid <= 1'b0;
		end else begin
			exp_valid <= instr_valid;
			if (instr_valid) begin
				exp_alu    <= m_alu;
				exp_wen    <= m_alu && (instr[11:7] != 5'd0);  // x0 never written
				exp_taken  <= m_taken;
				exp_rd     <= instr[11:7];
				exp_data   <= m_data;
				exp_target <= m_target;
			end
		end
	end

	// ========================================
	// checks, sampled mid cycle
	// ========================================
	a_reset: assert property (@(negedge clk)
		(rst_d1 || rst_d2) |-> !wb_valid && !wb_wen && !br_taken)
	else begin
		errors++;
		$display("reset: outputs not quiet during or right after reset");
	end
	a_valid: assert property (@(negedge clk) disable iff (rst) wb_valid == exp_valid)
	else begin
		errors++;
		$display("Mismatch wb_valid: expected %h, actual %h", exp_valid, wb_valid);
	end
	a_wen: assert property (@(negedge clk) disable iff (rst) exp_valid |-> wb_wen == exp_wen)
	else begin
		errors++;
		$display("Mismatch wb_wen: expected %h, actual %h", exp_wen, wb_wen);
	end
	a_taken: assert property (@(negedge clk) disable iff (rst)
		exp_valid |-> br_taken == exp_taken)
	else begin
		errors++;
		$display("Mismatch br_taken: expected %h, actual %h", exp_taken, br_taken);
	end
	a_rd: assert property (@(negedge clk) disable iff (rst)
		exp_valid |-> wb_rd_addr == exp_rd)
	else begin
		errors++;
		$display("Mismatch wb_rd_addr: expected %h, actual %h", exp_rd, wb_rd_addr);
	end
	a_data: assert property (@(negedge clk) disable iff (rst)
		exp_valid && exp_alu |-> wb_data == exp_data)
	else begin
		errors++;
		$display("Mismatch wb_data: expected %h, actual %h", exp_data, wb_data);
	end
	a_target: assert property (@(negedge clk) disable iff (rst)
		br_taken |-> br_target == exp_target)
	else begin
		errors++;
		$display("Mismatch br_target: expected %h, actual %h", exp_target, br_target);
	end

	// ========================================
	// encoders and drivers
	// ========================================
	function automatic reg_bus_t rand64();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [6:0] opc);
		return {f7, 5'd2, 5'd1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
		input logic [4:0] rd, input logic [6:0] opc);
		return {imm, 5'd1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] off, input logic [2:0] f3);
		return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], op_branch};
	endfunction

	function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, op_lui};
	endfunction

	task automatic issue(input logic [31:0] ins, input reg_bus_t a, input reg_bus_t b);
		@(posedge clk);
		instr_valid <= 1'b1;
		instr       <= ins;
		rs1_data    <= a;
		rs2_data    <= b;
		pc          <= rand64();
		issued++;
	endtask

	task automatic gap();
		@(posedge clk);
		instr_valid <= 1'b0;
	endtask

	// wait for the last result to leave the outputs
	task automatic drain();
		int n = 0;
		gap();
		do begin
			@(negedge clk);
			n++;
		end while (wb_valid && n < 8);
		if (wb_valid) begin
			$display("timeout: wb_valid still high 8 cycles after the last instruction");
			timed_out = 1'b1;
		end
	endtask

	task automatic end_test(input string name);
		drain();
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - test_base);
		test_base = errors;
	endtask

	// ========================================
	// stimulus
	// ========================================
	initial begin
		reg_bus_t   a;
		reg_bus_t   b;
		logic [2:0] f3;
		logic       alt;
		int         i;
		rst         = 1'b1;
		instr_valid = 1'b0;
		instr       = 32'h0;
		pc          = zero_word;
		rs1_data    = zero_word;
		rs2_data    = zero_word;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		end_test("reset");

		for (i = 0; i < 28; i++) begin
			f3 = alu_f3[i % 7];
			a  = rand64();
			b  = rand64();
			if (i < 14) begin
				issue(r_type((i % 7 == 1) ? 7'h20 : 7'h00, f3, 5'(i % 31 + 1), op_reg), a, b);
			end else begin
				issue(i_type(b[11:0], f3, 5'(i % 31 + 1), op_imm), a, b);
			end
		end
		issue(r_type(7'h00, 3'd2, 5'd5, op_reg), 64'h8000_0000_0000_0000, 64'd1);
		issue(r_type(7'h00, 3'd3, 5'd5, op_reg), 64'h8000_0000_0000_0000, 64'd1);
		issue(i_type(12'hfff, 3'd2, 5'd6, op_imm), 64'd5, zero_word);  // 5 < -1 signed
		issue(i_type(12'hfff, 3'd3, 5'd6, op_imm), 64'd5, zero_word);
		end_test("alu");

		for (i = 0; i < 12; i++) begin
			a   = rand64();
			b   = rand64();
			alt = (i % 3 == 2);                // arithmetic right shift
			f3  = (i % 3 == 0) ? 3'd1 : 3'd5;
			issue(r_type({1'b0, alt, 5'b0}, f3, 5'd7, op_reg), a, b);
			issue(i_type({1'b0, alt, 4'b0, b[5:0]}, f3, 5'd8, op_imm), a, b);
			issue(r_type({1'b0, alt, 5'b0}, f3, 5'd9, op_regw), a, b);
			issue(i_type({1'b0, alt, 5'b0, b[4:0]}, f3, 5'd10, op_immw), a, b);
			issue(r_type((i % 2 == 1) ? 7'h20 : 7'h00, 3'd0, 5'd11, op_regw), a, b);
		end
		issue(i_type(12'h43f, 3'd5, 5'd7, op_imm), 64'h8000_0000_0000_0001, zero_word);
		issue(r_type(7'h00, 3'd0, 5'd11, op_regw), 64'h0000_0000_7fff_ffff, 64'd1);
		issue(r_type(7'h20, 3'd0, 5'd11, op_regw), 64'hffff_ffff_8000_0000, 64'd1);
		issue(i_type(12'h001, 3'd0, 5'd12, op_immw), 64'h1234_5678_7fff_ffff, zero_word);
		issue(lui_word(20'h80000, 5'd13), zero_word, zero_word);
		issue(lui_word(20'h12345, 5'd13), zero_word, zero_word);
		end_test("shifts and w forms");

		for (i = 0; i < 30; i++) begin
			case (i / 6)
				0: begin
					a = rand64();
					b = a;
				end
				1: begin
					a = 64'hffff_ffff_ffff_fffe;   // signed less, unsigned greater
					b = 64'd3;
				end
				2: begin
					a = 64'd3;
					b = 64'hffff_ffff_ffff_fffe;
				end
				3: begin
					a = 64'd10;
					b = 64'd20;
				end
				default: begin
					a = 64'd20;
					b = 64'd10;
				end
			endcase
			issue(b_type(13'($random(seed)), br_f3[i % 6]), a, b);
		end
		end_test("branches");

		issue(r_type(7'h00, 3'd0, 5'd3, op_reg), rand64(), rand64());
		gap();
		issue(r_type(7'h00, 3'd0, 5'd0, op_reg), rand64(), rand64());     // rd is x0
		issue(i_type(12'h7ff, 3'd0, 5'd4, 7'b1111111), rand64(), rand64());
		gap();
		issue(b_type(13'h0010, 3'd2), 64'd1, 64'd1);                       // no such branch
		end_test("spacing and x0");

		$display("%0d tests, %0d instructions, %0d errors", tests, issued, errors);
		if (errors == 0 && !timed_out) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
